/* Makefile */
SIM      = verilator
FLAGS    = --binary --assert -Wno-fatal --Mdir obj_dir
TOP      = mseMonitorTb
FILELIST = src.f
LOG      = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: compile
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "Verification passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

/* log10Approx.sv */
`timescale 1ns/1ps

module log10Approx
(
    input  logic                                         clk,
    input  logic                                         reset,
    input  logic                                         load,
    input  logic        [mseMonitorPkg::ACC_BITS-1:0]    sumIn,
    output logic signed [mseMonitorPkg::LOG_BITS-1:0]    logOut,
    output logic                                         valid
);

    import mseMonitorPkg::*;

    localparam int X_BITS = 2*NUM_ITERS + 1;           // bit X_BITS-1 is 1.0

    logic        [NUM_ITERS-1:0]              normX;   // mantissa in [0.5, 1)
    logic        [$clog2(NORM_ENTRIES)-1:0]   normIdx; // row of NORM_LOG
    logic        [X_BITS-1:0]                 xStep [NUM_ITERS+1];
    logic signed [LOG_BITS-1:0]               logStep [NUM_ITERS+1];
    logic        [X_BITS-1:0]                 xTry [NUM_ITERS];
    logic                                     skip [NUM_ITERS];

    // leading-one search over bits 47..20, highest one wins
    always_comb
    begin
        normX = sumIn[NORM_LOW_BIT-1 -: NUM_ITERS];    // bottom bucket
        normIdx = ($clog2(NORM_ENTRIES))'(NORM_ENTRIES - 1);
        for (int p = NORM_LOW_BIT; p < ACC_BITS; p++)
        begin
            if (sumIn[p])
            begin
                normX = sumIn[p -: NUM_ITERS];
                normIdx = ($clog2(NORM_ENTRIES))'(ACC_BITS - 1 - p);
            end
        end
    end

    assign xStep[0]   = {1'b0, normX, {NUM_ITERS{1'b0}}};
    assign logStep[0] = NORM_LOG[normIdx];

    // drive x towards 1.0, collecting -log10 of each applied factor
    for (genvar k = 0; k < NUM_ITERS; k++)
    begin : gStep
        assign xTry[k] = xStep[k] + (xStep[k] >> (k + 1));      // x * (1 + 2^-(k+1))
        assign skip[k] = xTry[k][X_BITS-1] || (xStep[k] == '0); // overflow or empty sum
        assign xStep[k+1]   = skip[k] ? xStep[k] : xTry[k];
        assign logStep[k+1] = skip[k] ? logStep[k] : logStep[k] - X_SCALE_LOG[k];
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            valid <= 1'b0;
        end
        else
        begin
            valid <= load;                             // one-cycle latency
        end
    end

    always_ff @(posedge clk)
    begin
        if (load)
        begin
            logOut <= logStep[NUM_ITERS];              // held until next load
        end
    end

    // each result pulse comes from a load the cycle before
    assert property (@(posedge clk) disable iff (reset) $rose(valid) |-> $past(load))
        else $error("log10Approx valid without load");

endmodule

/* mseEstimator.sv */
`timescale 1ns/1ps

module mseEstimator
#(
    parameter int CHANNEL = 0
)
(
    input  logic                                          clk,
    input  logic                                          reset,
    input  logic                                          startEstimate,
    input  logic                                          magValid,
    input  logic        [mseMonitorPkg::MAG_BITS-1:0]     mag,
    input  logic        [mseMonitorPkg::MEAN_BITS-1:0]    meanMag,
    input  logic        [mseMonitorPkg::LEN_BITS-1:0]     avgLength,
    input  logic signed [mseMonitorPkg::LEN_BITS-1:0]     log10MseOffset,
    output logic                                          wbCyc,
    output logic                                          wbStb,
    output logic                                          wbWe,
    output logic        [mseMonitorPkg::WB_ADDR_BITS-1:0] wbAdr,
    output logic        [mseMonitorPkg::RESULT_BITS-1:0]  wbDatW,
    input  logic                                          wbAck,
    output logic                                          done
);

    import mseMonitorPkg::*;

    estState_t                  state;
    logic [LEN_BITS-1:0]        sampleCount;           // valid samples still to take
    logic                       takeSample;
    logic                       diffValid;             // diff holds a pending term
    logic signed [DIFF_BITS-1:0] diff;
    logic [2*DIFF_BITS-1:0]     diffSq;
    logic [ACC_BITS-1:0]        sum;
    logic                       logLoad;
    logic                       logValid;
    logic signed [LOG_BITS-1:0] logOut;
    logic signed [LOG_BITS-1:0] resultLog;

    assign takeSample = (state == EST_ACCUM) && magValid && (sampleCount != '0);
    assign diffSq     = diff * diff;                   // always non-negative
    assign logLoad    = (state == EST_LOG) && !logValid; // single load per estimate

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state       <= EST_IDLE;
            sampleCount <= '0;
            diffValid   <= 1'b0;
        end
        else
        begin
            diffValid <= takeSample;
            case (state)
                EST_IDLE:
                begin
                    if (startEstimate && magValid)     // start only counts on a valid cycle
                    begin
                        sampleCount <= avgLength;
                        state       <= EST_ACCUM;
                    end
                end
                EST_ACCUM:
                begin
                    if (takeSample)
                    begin
                        sampleCount <= sampleCount - 1'b1;
                    end
                    if (sampleCount == '0)             // last term lands this edge
                    begin
                        state <= EST_LOG;
                    end
                end
                EST_LOG:
                begin
                    if (logValid)
                    begin
                        state <= EST_WRITE;
                    end
                end
                EST_WRITE:
                begin
                    if (wbAck)
                    begin
                        state <= EST_IDLE;             // cyc drops next cycle
                    end
                end
                default:
                begin
                    state <= EST_IDLE;
                end
            endcase
        end
    end

    // error datapath, cleared by the start pulse
    always_ff @(posedge clk)
    begin
        if (state == EST_IDLE)
        begin
            sum <= '0;
        end
        else if (diffValid)
        begin
            sum <= sum + diffSq;
        end
        if (takeSample)
        begin
            diff <= $signed({mag, 5'b0}) - $signed({1'b0, meanMag, 1'b0}); // align scales
        end
    end

    log10Approx uLog
    (
        .clk    (clk),
        .reset  (reset),
        .load   (logLoad),
        .sumIn  (sum),
        .logOut (logOut),
        .valid  (logValid)
    );

    assign resultLog = logOut + log10MseOffset[LOG_BITS-1:0]; // offset folds in 1/K/mean^2
    assign wbDatW    = {{(RESULT_BITS-LOG_BITS){resultLog[LOG_BITS-1]}}, resultLog};
    assign wbAdr     = WB_ADDR_BITS'(CHANNEL);         // one word per channel
    assign wbCyc     = (state == EST_WRITE);
    assign wbStb     = (state == EST_WRITE);
    assign wbWe      = (state == EST_WRITE);
    assign done      = (state == EST_WRITE) && wbAck;

    // the write request and its data hold through any arbitration wait
    assert property (@(posedge clk) disable iff (reset)
        wbStb && !wbAck |=> wbStb && $stable(wbDatW))
        else $error("mseEstimator %0d dropped or changed a pending write", CHANNEL);

endmodule

/* mseMonitorPkg.sv */
package mseMonitorPkg;

    localparam int NUM_ITERS     = 6;                  // shift-and-add steps
    localparam int LOG_BITS      = 11;                 // Q4.7 log accumulator
    localparam int LOG_FRAC_BITS = 7;
    localparam int MAG_BITS      = 13;                 // Q0.13 magnitude
    localparam int MEAN_BITS     = 16;
    localparam int LEN_BITS      = 16;                 // avgLength and offset width
    localparam int DIFF_BITS     = 18;                 // signed error term
    localparam int ACC_BITS      = 48;                 // room for 14 bits of growth
    localparam int RESULT_BITS   = 16;                 // sign-extended Q4.7
    localparam int WB_ADDR_BITS  = 2;
    localparam int RESULT_DEPTH  = 4;

    localparam int NORM_LOW_BIT  = 20;                 // lowest bit with its own bucket
    localparam int NORM_ENTRIES  = 29;                 // exponents 14 down to -14

    // log10(1 + 2^-(k+1)) * 2^LOG_FRAC_BITS, rounded
    localparam logic signed [LOG_BITS-1:0] X_SCALE_LOG [NUM_ITERS] =
        '{23, 12, 7, 3, 2, 1};

    // log10(2^e) * 2^LOG_FRAC_BITS for e = 14 .. -14
    localparam logic signed [LOG_BITS-1:0] NORM_LOG [NORM_ENTRIES] =
        '{ 539,  501,  462,  424,  385,  347,  308,  270,  231,  193,
           154,  116,   77,   39,    0,  -39,  -77, -116, -154, -193,
          -231, -270, -308, -347, -385, -424, -462, -501, -539};

    typedef enum logic [1:0] {
        EST_IDLE,
        EST_ACCUM,
        EST_LOG,
        EST_WRITE
    } estState_t;

    typedef enum logic [1:0] {
        ARB_IDLE,
        ARB_GNT0,
        ARB_GNT1
    } arbState_t;

endpackage

/* mseMonitorTb.sv */
`timescale 1ns/1ps

module mseMonitorTb;

    import mseMonitorPkg::*;

    localparam int  OFFSET     = 37;                   // log10 offset fed to both channels
    localparam int  TOL        = 8;                    // LSB window on the Q4.7 result
    localparam int  LEN_TOTAL  = 32 + 64 + 100 + 4096 + 16 + 16; // avgLength of each run
    localparam int  TIMEOUT    = 4 * (LEN_TOTAL + 200);
    localparam real FULL_SCALE = 17179869184.0;        // 2^34, log of zero at this sum

    logic                       clk;
    logic                       reset;
    logic                       startEstimate0;
    logic                       startEstimate1;
    logic                       magValid0;
    logic                       magValid1;
    logic [MAG_BITS-1:0]        mag0;
    logic [MAG_BITS-1:0]        mag1;
    logic [MEAN_BITS-1:0]       meanMag;
    logic [LEN_BITS-1:0]        avgLength;
    logic signed [LEN_BITS-1:0] log10MseOffset;
    logic                       done0;
    logic                       done1;
    logic [WB_ADDR_BITS-1:0]    rdAddr;
    logic [RESULT_BITS-1:0]     rdData;

    logic [15:0] lfsr = 16'd7;                         // seed
    int          meanValue;
    int          cycleCount = 0;
    int          startCount0 = 0;                      // estimates launched per channel
    int          startCount1 = 0;
    int          doneCount0 = 0;
    int          doneCount1 = 0;
    int          doneCycle0 = 0;                       // cycle of the latest done
    int          doneCycle1 = 0;
    longint      sum0;                                 // model sums of the last run
    longint      sum1;

    tbClock #(.PERIOD(4.0), .RESET_CYCLES(4)) uClock (.clk(clk), .reset(reset));

    mseMonitorTop uut
    (
        .clk(clk), .reset(reset), .startEstimate0(startEstimate0),
        .startEstimate1(startEstimate1), .magValid0(magValid0), .magValid1(magValid1),
        .mag0(mag0), .mag1(mag1), .meanMag(meanMag), .avgLength(avgLength),
        .log10MseOffset(log10MseOffset), .done0(done0), .done1(done1),
        .rdAddr(rdAddr), .rdData(rdData)
    );

    task automatic stopOnFailure(input string why);
        $display("%s", why);
        $display("Verification failed");
        $fatal(1, "simulation stopped on first error");
    endtask

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsrStep(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic takeBits(input int n, output int value);
        value = 0;
        for (int i = 0; i < n; i++)
        begin
            lfsr  = lfsrStep(lfsr);                    // one step per bit
            value = (value << 1) | int'(lfsr[0]);
        end
    endtask

    function automatic int roundReal(input real x);
        if (x >= 0.0)
        begin
            return $rtoi(x + 0.5);
        end
        return -$rtoi(0.5 - x);
    endfunction

    // round(128 * log10(sum / 2^34)) plus offset, zero sum sits at 2^-14
    function automatic int expectedWord(input longint sum);
        real scaled;
        if (sum == 0)
        begin
            return roundReal(128.0 * $log10(1.0 / 16384.0)) + OFFSET;
        end
        scaled = 128.0 * $log10($itor(sum) / FULL_SCALE);
        return roundReal(scaled) + OFFSET;
    endfunction

    task automatic setConfig(input int mean, input int len);
        @(posedge clk);
        meanMag   <= MEAN_BITS'(mean);
        avgLength <= LEN_BITS'(len);
        meanValue = mean;
    endtask

    task automatic feedSamples(input bit use0, input bit use1, input int count,
                               input bit randomMag, input int m0, input int m1,
                               input int extra);
        int     taken;
        int     bits;
        int     mv0;
        int     mv1;
        bit     valid;
        longint e0;
        longint e1;
        taken = 0;
        sum0  = 0;
        sum1  = 0;
        @(posedge clk);
        startEstimate0 <= use0;                        // sample of the start cycle is skipped
        startEstimate1 <= use1;
        magValid0      <= use0;
        magValid1      <= use1;
        mag0           <= MAG_BITS'(m0);
        mag1           <= MAG_BITS'(m1);
        startCount0 += int'(use0);
        startCount1 += int'(use1);
        while (taken < count + extra)                  // extra samples arrive after the count
        begin
            @(posedge clk);
            startEstimate0 <= 1'b0;
            startEstimate1 <= 1'b0;
            valid = 1'b1;
            mv0   = m0;
            mv1   = m1;
            if (randomMag)
            begin
                takeBits(2, bits);
                valid = (bits != 0);                   // roughly one gap in four
                takeBits(12, mv0);
                mv1 = mv0;
            end
            if (!valid || taken >= count)
            begin
                mv0 = 0;                               // uncounted cycles carry a far-off error
                mv1 = 0;
            end
            magValid0 <= use0 && valid;
            magValid1 <= use1 && valid;
            mag0      <= MAG_BITS'(mv0);
            mag1      <= MAG_BITS'(mv1);
            if (valid && taken < count)
            begin
                e0 = longint'(mv0) * 32 - longint'(meanValue) * 2;
                e1 = longint'(mv1) * 32 - longint'(meanValue) * 2;
                sum0 += e0 * e0;
                sum1 += e1 * e1;
            end
            if (valid)
            begin
                taken++;
            end
        end
        @(posedge clk);
        magValid0 <= 1'b0;
        magValid1 <= 1'b0;
    endtask

    task automatic waitDone();
        while (doneCount0 < startCount0 || doneCount1 < startCount1)
        begin
            @(posedge clk);                            // timeout process bounds this
        end
    endtask

    task automatic checkWord(input string name, input int addr, input int expected,
                             input int tol);
        int actual;
        @(posedge clk);
        rdAddr <= WB_ADDR_BITS'(addr);
        @(posedge clk);
        @(posedge clk);                                // registered read is out now
        actual = int'($signed(rdData));
        assert ((actual - expected <= tol) && (expected - actual <= tol))
            else stopOnFailure($sformatf("MISMATCH %s: expected %0d actual %0d",
                                         name, expected, actual));
    endtask

    assert property (@(posedge clk) disable iff (reset) done0 |-> doneCount0 < startCount0)
        else stopOnFailure("done0 pulsed with no estimate pending on channel 0");
    assert property (@(posedge clk) disable iff (reset) done1 |-> doneCount1 < startCount1)
        else stopOnFailure("done1 pulsed with no estimate pending on channel 1");
    assert property (@(posedge clk) disable iff (reset) done0 |=> !done0)
        else stopOnFailure("done0 stayed high for more than one cycle");
    assert property (@(posedge clk) disable iff (reset) done1 |=> !done1)
        else stopOnFailure("done1 stayed high for more than one cycle");

    always @(posedge clk)
    begin
        if (done0)
        begin
            doneCount0 <= doneCount0 + 1;
            doneCycle0 <= cycleCount;
        end
        if (done1)
        begin
            doneCount1 <= doneCount1 + 1;
            doneCycle1 <= cycleCount;
        end
    end

    always @(posedge clk)
    begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= TIMEOUT)
        begin
            stopOnFailure($sformatf("simulation timed out after %0d cycles", TIMEOUT));
        end
    end

    initial
    begin
        int a;
        startEstimate0 <= 1'b0;
        startEstimate1 <= 1'b0;
        magValid0      <= 1'b0;
        magValid1      <= 1'b0;
        mag0           <= '0;
        mag1           <= '0;
        meanMag        <= '0;
        avgLength      <= '0;
        log10MseOffset <= LEN_BITS'(OFFSET);
        rdAddr         <= '0;
        meanValue = 0;
        @(posedge clk);
        while (reset)
        begin
            @(posedge clk);
        end

        repeat (20) @(posedge clk);                    // idle, no done expected
        for (a = 0; a < RESULT_DEPTH; a++)
        begin
            checkWord("resetClear", a, 0, 0);
        end

        // tie on the bus, first one after reset
        setConfig(20000, 32);
        feedSamples(1'b1, 1'b1, 32, 1'b0, 3000, 1000, 8);
        waitDone();
        assert (doneCycle0 < doneCycle1)
            else stopOnFailure("channel 1 was written before channel 0 on the first tie");
        checkWord("bothChannels0", 0, expectedWord(sum0), TOL);
        checkWord("bothChannels1", 1, expectedWord(sum1), TOL);

        setConfig(20000, 64);                          // diff of 24000 on every sample
        feedSamples(1'b1, 1'b0, 64, 1'b0, 2000, 0, 8);
        waitDone();
        checkWord("constantMag", 0, expectedWord(sum0), TOL);

        setConfig(32768, 100);                         // 12-bit mags keep diff in range
        feedSamples(1'b0, 1'b1, 100, 1'b1, 0, 0, 8);
        waitDone();
        checkWord("randomGaps", 1, expectedWord(sum1), TOL);

        setConfig(65535, 4096);                        // largest diff the datapath holds
        feedSamples(1'b1, 1'b0, 4096, 1'b0, 0, 0, 8);
        waitDone();
        checkWord("largeSum", 0, expectedWord(sum0), TOL);

        setConfig(16000, 16);                          // mag * 32 equals mean * 2
        feedSamples(1'b0, 1'b1, 16, 1'b0, 0, 1000, 8);
        waitDone();
        checkWord("zeroSum", 1, expectedWord(sum1), 0);

        setConfig(20000, 16);
        feedSamples(1'b1, 1'b0, 16, 1'b0, 2500, 0, 0);
        while (!uut.cyc0)
        begin
            @(posedge clk);
        end
        startEstimate0 <= 1'b1;                        // lands while the write is pending
        magValid0      <= 1'b1;
        @(posedge clk);
        startEstimate0 <= 1'b0;
        waitDone();
        repeat (36)                                    // long enough for a stray estimate
        begin
            @(posedge clk);
            mag0 <= MAG_BITS'(500);
        end
        @(posedge clk);
        magValid0 <= 1'b0;
        checkWord("startDuringWrite", 0, expectedWord(sum0), TOL);

        $display("Verification passed");
        $finish;
    end

endmodule

/* mseMonitorTop.sv */
`timescale 1ns/1ps

module mseMonitorTop
(
    input  logic                                          clk,
    input  logic                                          reset,
    input  logic                                          startEstimate0,
    input  logic                                          startEstimate1,
    input  logic                                          magValid0,
    input  logic                                          magValid1,
    input  logic        [mseMonitorPkg::MAG_BITS-1:0]     mag0,
    input  logic        [mseMonitorPkg::MAG_BITS-1:0]     mag1,
    input  logic        [mseMonitorPkg::MEAN_BITS-1:0]    meanMag,
    input  logic        [mseMonitorPkg::LEN_BITS-1:0]     avgLength,
    input  logic signed [mseMonitorPkg::LEN_BITS-1:0]     log10MseOffset,
    output logic                                          done0,
    output logic                                          done1,
    input  logic        [mseMonitorPkg::WB_ADDR_BITS-1:0] rdAddr,
    output logic        [mseMonitorPkg::RESULT_BITS-1:0]  rdData
);

    import mseMonitorPkg::*;

    logic                    cyc0, stb0, we0, ack0;    // channel 0 master
    logic [WB_ADDR_BITS-1:0] adr0;
    logic [RESULT_BITS-1:0]  dat0;
    logic                    cyc1, stb1, we1, ack1;    // channel 1 master
    logic [WB_ADDR_BITS-1:0] adr1;
    logic [RESULT_BITS-1:0]  dat1;
    logic                    busCyc, busStb, busWe, busAck; // shared bus to memory
    logic [WB_ADDR_BITS-1:0] busAdr;
    logic [RESULT_BITS-1:0]  busDat;

    mseEstimator #(.CHANNEL(0)) uEst0
    (
        .clk(clk), .reset(reset), .startEstimate(startEstimate0), .magValid(magValid0),
        .mag(mag0), .meanMag(meanMag), .avgLength(avgLength),
        .log10MseOffset(log10MseOffset), .wbCyc(cyc0), .wbStb(stb0), .wbWe(we0),
        .wbAdr(adr0), .wbDatW(dat0), .wbAck(ack0), .done(done0)
    );

    mseEstimator #(.CHANNEL(1)) uEst1
    (
        .clk(clk), .reset(reset), .startEstimate(startEstimate1), .magValid(magValid1),
        .mag(mag1), .meanMag(meanMag), .avgLength(avgLength),
        .log10MseOffset(log10MseOffset), .wbCyc(cyc1), .wbStb(stb1), .wbWe(we1),
        .wbAdr(adr1), .wbDatW(dat1), .wbAck(ack1), .done(done1)
    );

    wbArbiter uArb
    (
        .clk(clk), .reset(reset),
        .cyc0(cyc0), .stb0(stb0), .we0(we0), .adr0(adr0), .dat0(dat0), .ack0(ack0),
        .cyc1(cyc1), .stb1(stb1), .we1(we1), .adr1(adr1), .dat1(dat1), .ack1(ack1),
        .busCyc(busCyc), .busStb(busStb), .busWe(busWe), .busAdr(busAdr),
        .busDat(busDat), .busAck(busAck)
    );

    resultRam uRam
    (
        .clk(clk), .reset(reset), .wbCyc(busCyc), .wbStb(busStb), .wbWe(busWe),
        .wbAdr(busAdr), .wbDat(busDat), .wbAck(busAck),
        .rdAddr(rdAddr), .rdData(rdData)
    );

endmodule

/* resultRam.sv */
`timescale 1ns/1ps

module resultRam
(
    input  logic                                          clk,
    input  logic                                          reset,
    input  logic                                          wbCyc,
    input  logic                                          wbStb,
    input  logic                                          wbWe,
    input  logic        [mseMonitorPkg::WB_ADDR_BITS-1:0] wbAdr,
    input  logic        [mseMonitorPkg::RESULT_BITS-1:0]  wbDat,
    output logic                                          wbAck,
    input  logic        [mseMonitorPkg::WB_ADDR_BITS-1:0] rdAddr,
    output logic        [mseMonitorPkg::RESULT_BITS-1:0]  rdData
);

    import mseMonitorPkg::*;

    logic [RESULT_BITS-1:0] mem [RESULT_DEPTH];
    logic                   newCycle;                  // first cycle of cyc and stb

    assign newCycle = wbCyc && wbStb && !wbAck;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            wbAck <= 1'b0;
            for (int i = 0; i < RESULT_DEPTH; i++)
            begin
                mem[i] <= '0;                          // results read zero until written
            end
        end
        else
        begin
            wbAck <= newCycle;                         // single-cycle ack
            if (newCycle && wbWe)
            begin
                mem[wbAdr] <= wbDat;                   // word lands as ack goes out
            end
        end
    end

    always_ff @(posedge clk)
    begin
        rdData <= mem[rdAddr];                         // host read, one cycle
    end

    // ack always answers a request seen the cycle before
    assert property (@(posedge clk) disable iff (reset) wbAck |-> $past(wbCyc && wbStb))
        else $error("resultRam ack without request");

endmodule

/* src.f */
mseMonitorPkg.sv
log10Approx.sv
mseEstimator.sv
wbArbiter.sv
resultRam.sv
mseMonitorTop.sv
tbClock.sv
mseMonitorTb.sv

/* tbClock.sv */
`timescale 1ns/1ps

module tbClock
#(
    parameter real PERIOD       = 4.0,                 // ns
    parameter int  RESET_CYCLES = 4
)
(
    output logic clk,
    output logic reset
);

    initial
    begin
        clk = 1'b0;
        forever #(PERIOD / 2.0) clk = ~clk;
    end

    initial
    begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;                                 // released on a rising edge
    end

endmodule

/* wbArbiter.sv */
`timescale 1ns/1ps

module wbArbiter
(
    input  logic                                          clk,
    input  logic                                          reset,
    input  logic                                          cyc0,
    input  logic                                          stb0,
    input  logic                                          we0,
    input  logic        [mseMonitorPkg::WB_ADDR_BITS-1:0] adr0,
    input  logic        [mseMonitorPkg::RESULT_BITS-1:0]  dat0,
    output logic                                          ack0,
    input  logic                                          cyc1,
    input  logic                                          stb1,
    input  logic                                          we1,
    input  logic        [mseMonitorPkg::WB_ADDR_BITS-1:0] adr1,
    input  logic        [mseMonitorPkg::RESULT_BITS-1:0]  dat1,
    output logic                                          ack1,
    output logic                                          busCyc,
    output logic                                          busStb,
    output logic                                          busWe,
    output logic        [mseMonitorPkg::WB_ADDR_BITS-1:0] busAdr,
    output logic        [mseMonitorPkg::RESULT_BITS-1:0]  busDat,
    input  logic                                          busAck
);

    import mseMonitorPkg::*;

    arbState_t state;
    logic      lastServed;                             // 1 when channel 1 had the bus last

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state      <= ARB_IDLE;
            lastServed <= 1'b1;                        // so channel 0 wins the first tie
        end
        else
        begin
            case (state)
                ARB_IDLE:
                begin
                    if (cyc0 && (!cyc1 || lastServed))
                    begin
                        state      <= ARB_GNT0;
                        lastServed <= 1'b0;
                    end
                    else if (cyc1)
                    begin
                        state      <= ARB_GNT1;
                        lastServed <= 1'b1;
                    end
                end
                ARB_GNT0:
                begin
                    if (!cyc0)
                    begin
                        state <= ARB_IDLE;             // release when cycle ends
                    end
                end
                ARB_GNT1:
                begin
                    if (!cyc1)
                    begin
                        state <= ARB_IDLE;
                    end
                end
                default:
                begin
                    state <= ARB_IDLE;
                end
            endcase
        end
    end

    // bus mux, nothing driven while idle
    always_comb
    begin
        busCyc = 1'b0;
        busStb = 1'b0;
        busWe  = 1'b0;
        busAdr = '0;
        busDat = '0;
        case (state)
            ARB_GNT0:
            begin
                busCyc = cyc0;
                busStb = stb0;
                busWe  = we0;
                busAdr = adr0;
                busDat = dat0;
            end
            ARB_GNT1:
            begin
                busCyc = cyc1;
                busStb = stb1;
                busWe  = we1;
                busAdr = adr1;
                busDat = dat1;
            end
            default:
            begin
                busCyc = 1'b0;
            end
        endcase
    end

    assign ack0 = busAck && (state == ARB_GNT0);      // ack only to the owner
    assign ack1 = busAck && (state == ARB_GNT1);

    assert property (@(posedge clk) disable iff (reset) !(ack0 && ack1))
        else $error("wbArbiter acked both masters");

endmodule
